// ==== trellisDetector.f ====
+incdir+hdl
hdl/trellisPkg.sv
hdl/rotIf.sv
hdl/acsIf.sv
hdl/phaseRotator.sv
hdl/compSel.sv
hdl/acsUnit.sv
hdl/pathMetricBank.sv
hdl/trellisDetector.sv
tb/trellisDetectorTb.sv

// ==== Bender.yml ====
package:
  name: trellisDetector

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/trellisPkg.sv
      - hdl/rotIf.sv
      - hdl/acsIf.sv
      - hdl/phaseRotator.sv
      - hdl/compSel.sv
      - hdl/acsUnit.sv
      - hdl/pathMetricBank.sv
      - hdl/trellisDetector.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/trellisDetectorTb.sv

// ==== tb/trellisDetectorTb.sv ====
`timescale 1ns/10ps
`include "trellis_cfg.svh"

module trellisDetectorTb;

   localparam int SYM_TIMEOUT = 20;

   logic clk = 1'b0;
   logic reset;
   logic symEn;
   logic sym2xEn;
   logic symEnEven;
   logic [`ANGLE_BITS-1:0] tilt;
   logic [`MF_BITS-1:0] iIn;
   logic [`MF_BITS-1:0] qIn;
   logic symEnOut;
   logic sym2xEnOut;
   logic [1:0] bestState;
   trellisPkg::metricT bestMetric;
   trellisPkg::sampleT iOut;
   trellisPkg::sampleT qOut;
   logic [2*`NUM_STATES-1:0] selOut;

   logic [31:0] lfsr = 32'hb704d55b;
   logic [`SYM_LATENCY-1:0] sym2xHist = '0;
   int sinceSym = -1;
   bit firstDone = 1'b0;
   bit nextEven = 1'b1;
   int modelMet [`NUM_STATES] = '{default: 0};
   int normCount = 0;
   int tieCount = 0;

   trellisDetector UUT (
      .clk        (clk),
      .reset      (reset),
      .symEn      (symEn),
      .sym2xEn    (sym2xEn),
      .symEnEven  (symEnEven),
      .tilt       (tilt),
      .iIn        (iIn),
      .qIn        (qIn),
      .symEnOut   (symEnOut),
      .sym2xEnOut (sym2xEnOut),
      .bestState  (bestState),
      .bestMetric (bestMetric),
      .iOut       (iOut),
      .qOut       (qOut),
      .selOut     (selOut)
   );

   always #2 clk = ~clk;

   task automatic reportFailure();
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic checkValue(input string name, input int got, input int expected);
      assert (got == expected) else begin
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
         reportFailure();
      end
   endtask

   // right-shifting Galois LFSR that steps once for every output bit
   function automatic int takeBits(input int n);
      int val;
      val = 0;
      for (int b = 0; b < n; b++) begin
         val = (val << 1) | lfsr[0];
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return val;
   endfunction

   // cosine of a*pi/16 folded by symmetry onto the first-quadrant table
   function automatic int cosOf(input int a);
      int m;
      m = ((a % 32) + 32) % 32;
      if (m > 16) begin
         m = 32 - m;
      end
      if (m <= 8) begin
         return trellisPkg::cosLut[m];
      end
      return -int'(trellisPkg::cosLut[16 - m]);
   endfunction

   // floor away the 6 fraction bits, then clamp to +-127
   function automatic int scaleSat(input int acc);
      int v;
      v = acc >>> 6;
      if (v > 127) begin
         return 127;
      end
      if (v < -127) begin
         return -127;
      end
      return v;
   endfunction

   task automatic stepCycle();
      sym2xHist = {sym2xHist[`SYM_LATENCY-2:0], sym2xEn};
      @(posedge clk);
      #1;
      checkValue("sym2xEnOut", sym2xEnOut, sym2xHist[`SYM_LATENCY-1]);
      if (sinceSym >= 0) begin
         sinceSym++;
      end
      if (symEnOut) begin
         checkValue("symEnOut latency", sinceSym, `SYM_LATENCY);
      end else if (!firstDone) begin
         checkValue("bestState", bestState, 0);
         checkValue("bestMetric", bestMetric, 0);
         checkValue("iOut", iOut, 0);
         checkValue("qOut", qOut, 0);
         checkValue("selOut", selOut, 0);
      end
      symEn = 1'b0;
      sym2xEn = 1'b0;
   endtask

   // model first, then drive one symbol and compare on symEnOut
   task automatic runSymbol(input logic [`MF_BITS-1:0] iVal, input logic [`MF_BITS-1:0] qVal,
                            input int tiltVal, input int gap);
      int si;
      int sq;
      int h;
      int a;
      int c;
      int sn;
      int waited;
      int expBest;
      bit norm;
      int ri [4];
      int rq [4];
      int sum [4];
      int expSel [4];
      int newM [4];
      int bi [4];
      int bq [4];
      si = int'($signed(iVal[`MF_BITS-1 -: `ROT_BITS]));
      sq = int'($signed(qVal[`MF_BITS-1 -: `ROT_BITS]));
      h = nextEven ? 4 : 5;
      norm = 1'b0;
      for (int s = 0; s < 4; s++) begin
         for (int k = 0; k < 4; k++) begin
            a = 32 - tiltVal - 2 * ((h * k + s) % 16);
            c = cosOf(a);
            sn = cosOf(a - 8);
            ri[k] = scaleSat(si * c - sq * sn);
            rq[k] = scaleSat(si * sn + sq * c);
            sum[k] = modelMet[(s - k + 4) % 4] + ri[k];
         end
         expSel[s] = 0;
         for (int k = 1; k < 4; k++) begin
            if (sum[k] > sum[expSel[s]]) begin
               expSel[s] = k;
            end
         end
         if (sum[0] == sum[1] && sum[1] == sum[2] && sum[2] == sum[3]) begin
            tieCount++;
         end
         newM[s] = sum[expSel[s]];
         bi[s] = ri[expSel[s]];
         bq[s] = rq[expSel[s]];
         if (newM[s] >= 1024 && newM[s] < 2048) begin
            norm = 1'b1;
         end
      end
      if (norm) begin
         normCount++;
      end
      expBest = 0;
      for (int s = 0; s < 4; s++) begin
         if (norm) begin
            newM[s] = newM[s] - 1024;
         end
         modelMet[s] = newM[s];
         if (newM[s] > newM[expBest]) begin
            expBest = s;
         end
      end

      stepCycle();
      symEn = 1'b1;
      sym2xEn = 1'b1;
      symEnEven = nextEven;
      tilt = tiltVal;
      iIn = iVal;
      qIn = qVal;
      sinceSym = 0;
      nextEven = !nextEven;
      waited = 0;
      while (!symEnOut) begin
         if (waited >= SYM_TIMEOUT) begin
            $display("symEnOut did not arrive within %0d cycles of symEn", SYM_TIMEOUT);
            reportFailure();
         end else begin
            stepCycle();
            waited++;
            // the half-symbol strobe lands mid-way between symbols
            if (waited == gap / 2) begin
               sym2xEn = 1'b1;
            end
         end
      end
      firstDone = 1'b1;
      sinceSym = -1;
      for (int s = 0; s < 4; s++) begin
         checkValue($sformatf("selOut[%0d]", s), selOut[2*s +: 2], expSel[s]);
      end
      checkValue("bestState", bestState, expBest);
      checkValue("bestMetric", bestMetric, newM[expBest]);
      checkValue("iOut", iOut, bi[expBest]);
      checkValue("qOut", qOut, bq[expBest]);
      for (int c9 = `SYM_LATENCY + 1; c9 < gap; c9++) begin
         stepCycle();
      end
   endtask

   initial begin
      int i;
      int q;
      int t;
      int g;
      reset = 1'b1;
      symEn = 1'b0;
      sym2xEn = 1'b0;
      symEnEven = 1'b1;
      tilt = '0;
      iIn = '0;
      qIn = '0;
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;

      // tilt 0 puts the state-0 branch-0 angle at zero, tilt 24 at a quarter turn
      for (int n = 0; n < 6; n++) begin
         i = takeBits(`MF_BITS);
         q = takeBits(`MF_BITS);
         t = takeBits(`ANGLE_BITS);
         g = takeBits(2);
         runSymbol(i, q, (n < 2) ? 0 : ((n < 4) ? 24 : t), 9 + g);
      end

      for (int n = 0; n < 40; n++) begin
         i = takeBits(`MF_BITS);
         q = takeBits(`MF_BITS);
         t = takeBits(`ANGLE_BITS);
         g = takeBits(2);
         runSymbol(i, q, t, 9 + g);
      end

      // large positive I pushes every metric toward the overflow threshold
      for (int n = 0; n < 40; n++) begin
         i = takeBits(4);
         g = takeBits(2);
         runSymbol(10'h1f0 | i, 10'h000, 0, 9 + g);
      end

      // zero samples make all branch sums equal after the first symbol
      for (int n = 0; n < 4; n++) begin
         t = takeBits(`ANGLE_BITS);
         runSymbol(10'h000, 10'h000, t, 9);
      end

      if (normCount == 0 || tieCount == 0) begin
         $display("normalization or equal-sum case was never reached by the stimulus");
         reportFailure();
      end else begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule

// ==== hdl/trellisDetector.sv ====
`timescale 1ns/10ps
`include "trellis_cfg.svh"

module trellisDetector (
   input logic clk,
   input logic reset,
   input logic symEn,
   input logic sym2xEn,
   input logic symEnEven,
   input logic [`ANGLE_BITS-1:0] tilt,
   input logic [`MF_BITS-1:0] iIn,
   input logic [`MF_BITS-1:0] qIn,
   output logic symEnOut,
   output logic sym2xEnOut,
   output logic [1:0] bestState,
   output trellisPkg::metricT bestMetric,
   output trellisPkg::sampleT iOut,
   output trellisPkg::sampleT qOut,
   output logic [2*`NUM_STATES-1:0] selOut
);

   acsIf acsBus [`NUM_STATES] ();

   logic [`SYM_LATENCY-1:0] sym2xDelay;

   // one ACS unit per trellis state, each with its own rotator
   for (genvar gs = 0; gs < `NUM_STATES; gs++) begin : gAcs
      acsUnit #(
         .STATE (gs)
      ) acs (
         .clk       (clk),
         .reset     (reset),
         .symEn     (symEn),
         .symEnEven (symEnEven),
         .tilt      (tilt),
         .iIn       (iIn),
         .qIn       (qIn),
         .acs       (acsBus[gs])
      );
   end

   pathMetricBank bank (
      .clk        (clk),
      .reset      (reset),
      .acs        (acsBus),
      .symEnOut   (symEnOut),
      .bestState  (bestState),
      .bestMetric (bestMetric),
      .iOut       (iOut),
      .qOut       (qOut),
      .selOut     (selOut)
   );

   // the half-symbol strobe is aligned with the bank outputs
   always_ff @(posedge clk) begin
      if (reset) begin
         sym2xDelay <= '0;
      end else begin
         sym2xDelay <= {sym2xDelay[`SYM_LATENCY-2:0], sym2xEn};
      end
   end

   assign sym2xEnOut = sym2xDelay[`SYM_LATENCY-1];

endmodule

// ==== hdl/pathMetricBank.sv ====
`timescale 1ns/10ps
`include "trellis_cfg.svh"

module pathMetricBank (
   input logic clk,
   input logic reset,
   acsIf.bank acs [`NUM_STATES],
   output logic symEnOut,
   output logic [1:0] bestState,
   output trellisPkg::metricT bestMetric,
   output trellisPkg::sampleT iOut,
   output trellisPkg::sampleT qOut,
   output logic [2*`NUM_STATES-1:0] selOut
);

   localparam trellisPkg::metricT NORM_STEP = trellisPkg::metricT'(1 << (`ACS_BITS - 2));

   trellisPkg::metricT metric [`NUM_STATES];
   trellisPkg::metricT newMet [`NUM_STATES];
   trellisPkg::metricT nextMet [`NUM_STATES];
   trellisPkg::sampleT iBest [`NUM_STATES];
   trellisPkg::sampleT qBest [`NUM_STATES];
   logic [1:0] sel [`NUM_STATES];
   logic [`NUM_STATES-1:0] doneVec;
   logic [`NUM_STATES-1:0] normVec;
   logic [1:0] winState;
   logic load;

   for (genvar gs = 0; gs < `NUM_STATES; gs++) begin : gState
      assign newMet[gs] = acs[gs].newMet;
      assign iBest[gs] = acs[gs].iBest;
      assign qBest[gs] = acs[gs].qBest;
      assign sel[gs] = acs[gs].sel;
      assign doneVec[gs] = acs[gs].done;
      assign normVec[gs] = acs[gs].normReq;
      // fixed trellis wiring from stored metrics to each unit's branches
      for (genvar gk = 0; gk < `NUM_STATES; gk++) begin : gBranch
         assign acs[gs].candMet[gk] = metric[trellisPkg::predecessor(2'(gs), 2'(gk))];
      end
   end

   // all units run in lockstep and finish together
   assign load = &doneVec;

   // one request from any state pulls every metric down by the same step
   always_comb begin
      for (int s = 0; s < `NUM_STATES; s++) begin
         nextMet[s] = (|normVec) ? newMet[s] - NORM_STEP : newMet[s];
      end
   end

   always_comb begin
      winState = '0;
      for (int s = 1; s < `NUM_STATES; s++) begin
         if (nextMet[s] > nextMet[winState]) begin
            winState = 2'(s);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < `NUM_STATES; s++) begin
            metric[s] <= '0;
         end
         symEnOut <= 1'b0;
         bestState <= '0;
         bestMetric <= '0;
         iOut <= '0;
         qOut <= '0;
         selOut <= '0;
      end else begin
         symEnOut <= load;
         if (load) begin
            for (int s = 0; s < `NUM_STATES; s++) begin
               metric[s] <= nextMet[s];
               selOut[2*s +: 2] <= sel[s];
            end
            bestState <= winState;
            bestMetric <= nextMet[winState];
            iOut <= iBest[winState];
            qOut <= qBest[winState];
         end
      end
   end

endmodule

// ==== hdl/acsUnit.sv ====
`timescale 1ns/10ps
`include "trellis_cfg.svh"

module acsUnit #(
   parameter int STATE = 0
) (
   input logic clk,
   input logic reset,
   input logic symEn,
   input logic symEnEven,
   input logic [`ANGLE_BITS-1:0] tilt,
   input logic [`MF_BITS-1:0] iIn,
   input logic [`MF_BITS-1:0] qIn,
   acsIf.unit acs
);

   rotIf rotBus ();

   logic [1:0] hypCnt;
   trellisPkg::symParityT parityReg;
   trellisPkg::symParityT parityNow;
   logic [1:0] capCnt;
   logic lastCap;
   trellisPkg::sampleT iRot [`NUM_STATES];
   trellisPkg::sampleT qRot [`NUM_STATES];
   trellisPkg::metricT sums [`NUM_STATES];
   trellisPkg::metricT maxVal;
   logic [1:0] index;

   // branch 0 goes out with symEn itself, branches 1 to 3 follow
   // and the counter parks at 0 once it wraps
   always_ff @(posedge clk) begin
      if (reset) begin
         hypCnt <= '0;
         parityReg <= trellisPkg::parityEven;
      end else if (symEn) begin
         hypCnt <= 2'd1;
         parityReg <= parityNow;
      end else if (hypCnt != 2'd0) begin
         hypCnt <= hypCnt + 2'd1;
      end
   end

   // parity is sampled at symEn and held for the rest of the symbol
   assign parityNow = symEn ? (symEnEven ? trellisPkg::parityEven : trellisPkg::parityOdd)
                            : parityReg;

   assign rotBus.strobe = symEn || (hypCnt != 2'd0);
   assign rotBus.iIn = iIn[`MF_BITS-1 -: `ROT_BITS];
   assign rotBus.qIn = qIn[`MF_BITS-1 -: `ROT_BITS];
   assign rotBus.angle = trellisPkg::branchAngle(2'(STATE), hypCnt, parityNow, tilt);

   phaseRotator rotator (
      .clk   (clk),
      .reset (reset),
      .rot   (rotBus)
   );

   // the capture counter follows valid, so it runs two cycles behind hypCnt
   always_ff @(posedge clk) begin
      if (reset) begin
         capCnt <= '0;
         lastCap <= 1'b0;
         acs.done <= 1'b0;
      end else begin
         lastCap <= rotBus.valid && (capCnt == 2'd3);
         acs.done <= lastCap;
         if (rotBus.valid) begin
            capCnt <= capCnt + 2'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rotBus.valid) begin
         iRot[capCnt] <= rotBus.iOut;
         qRot[capCnt] <= rotBus.qOut;
      end
   end

   // only the real part of each hypothesis counts toward the metric
   always_comb begin
      for (int k = 0; k < `NUM_STATES; k++) begin
         sums[k] = trellisPkg::metricT'(iRot[k]) + acs.candMet[k];
      end
   end

   // lastCap is high in the cycle after the fourth capture
   compSel selector (
      .clk    (clk),
      .reset  (reset),
      .ce     (lastCap),
      .sums   (sums),
      .maxVal (maxVal),
      .index  (index)
   );

   assign acs.newMet = maxVal;
   assign acs.sel = index;

   // the rotated sample of the winning branch feeds the phase-error path
   assign acs.iBest = iRot[index];
   assign acs.qBest = qRot[index];

   // top bits 01 means the metric is within a quarter range of wrapping
   assign acs.normReq = (maxVal[`ACS_BITS-1 -: 2] == 2'b01);

endmodule

// ==== hdl/compSel.sv ====
`timescale 1ns/10ps
`include "trellis_cfg.svh"

module compSel (
   input logic clk,
   input logic reset,
   input logic ce,
   input trellisPkg::metricT sums [`NUM_STATES],
   output trellisPkg::metricT maxVal,
   output logic [1:0] index
);

   trellisPkg::metricT bestSum;
   logic [1:0] bestIdx;

   // a later sum has to be strictly larger to win, so ties keep the lowest index
   always_comb begin
      bestSum = sums[0];
      bestIdx = 2'd0;
      for (int k = 1; k < `NUM_STATES; k++) begin
         if (sums[k] > bestSum) begin
            bestSum = sums[k];
            bestIdx = 2'(k);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         maxVal <= '0;
         index <= '0;
      end else if (ce) begin
         maxVal <= bestSum;
         index <= bestIdx;
      end
   end

endmodule

// ==== hdl/phaseRotator.sv ====
`timescale 1ns/10ps
`include "trellis_cfg.svh"

module phaseRotator (
   input logic clk,
   input logic reset,
   rotIf.rotator rot
);

   localparam int FRAC_BITS = `ROT_BITS - 2;
   localparam int ACC_BITS = 2 * `ROT_BITS + 1;
   localparam int SHIFT_BITS = ACC_BITS - FRAC_BITS;
   localparam logic signed [SHIFT_BITS-1:0] SAT_MAX = (1 <<< (`ROT_BITS - 1)) - 1;

   logic [1:0] quad;
   logic [`ANGLE_BITS-3:0] step;
   logic signed [`ROT_BITS-1:0] lutCos;
   logic signed [`ROT_BITS-1:0] lutSin;
   logic signed [`ROT_BITS-1:0] cosNext;
   logic signed [`ROT_BITS-1:0] sinNext;
   logic signed [`ROT_BITS-1:0] cosReg;
   logic signed [`ROT_BITS-1:0] sinReg;
   logic signed [`ROT_BITS-1:0] iReg;
   logic signed [`ROT_BITS-1:0] qReg;
   logic strobeReg;
   logic signed [ACC_BITS-1:0] iAcc;
   logic signed [ACC_BITS-1:0] qAcc;

   // drop the fraction bits, then clamp symmetrically so that -128 never appears
   function automatic logic signed [`ROT_BITS-1:0] saturate(input logic signed [ACC_BITS-1:0] acc);
      logic signed [SHIFT_BITS-1:0] scaled;
      scaled = acc[ACC_BITS-1:FRAC_BITS];
      if (scaled > SAT_MAX) begin
         return `ROT_BITS'(SAT_MAX);
      end else if (scaled < -SAT_MAX) begin
         return `ROT_BITS'(-SAT_MAX);
      end
      return `ROT_BITS'(scaled);
   endfunction

   // the table covers one quadrant, the sine is the mirrored cosine
   assign quad = rot.angle[`ANGLE_BITS-1 -: 2];
   assign step = rot.angle[`ANGLE_BITS-3:0];
   assign lutCos = $signed({1'b0, trellisPkg::cosLut[step]});
   assign lutSin = $signed({1'b0, trellisPkg::cosLut[4'd8 - step]});

   always_comb begin
      case (quad)
         2'd0: begin
            cosNext = lutCos;
            sinNext = lutSin;
         end
         2'd1: begin
            cosNext = -lutSin;
            sinNext = lutCos;
         end
         2'd2: begin
            cosNext = -lutCos;
            sinNext = -lutSin;
         end
         default: begin
            cosNext = lutSin;
            sinNext = -lutCos;
         end
      endcase
   end

   // stage 1 holds the coefficients next to the sample they apply to
   always_ff @(posedge clk) begin
      cosReg <= cosNext;
      sinReg <= sinNext;
      iReg <= rot.iIn;
      qReg <= rot.qIn;
   end

   assign iAcc = iReg * cosReg - qReg * sinReg;
   assign qAcc = iReg * sinReg + qReg * cosReg;

   always_ff @(posedge clk) begin
      rot.iOut <= saturate(iAcc);
      rot.qOut <= saturate(qAcc);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         strobeReg <= 1'b0;
         rot.valid <= 1'b0;
      end else begin
         strobeReg <= rot.strobe;
         rot.valid <= strobeReg;
      end
   end

endmodule

// ==== hdl/acsIf.sv ====
`timescale 1ns/10ps
`include "trellis_cfg.svh"

interface acsIf;
   // candMet[k] is the stored metric of the predecessor on branch k
   trellisPkg::metricT candMet [`NUM_STATES];

   trellisPkg::metricT newMet;
   logic [1:0] sel;
   trellisPkg::sampleT iBest;
   trellisPkg::sampleT qBest;
   logic normReq;
   // single-cycle pulse, all unit outputs are valid with it
   logic done;

   modport bank (
      output candMet,
      input newMet, sel, iBest, qBest, normReq, done
   );

   modport unit (
      input candMet,
      output newMet, sel, iBest, qBest, normReq, done
   );
endinterface

// ==== hdl/rotIf.sv ====
`timescale 1ns/10ps
`include "trellis_cfg.svh"

// one rotation request per strobe, the answer comes back two cycles later
interface rotIf;
   logic signed [`ROT_BITS-1:0] iIn;
   logic signed [`ROT_BITS-1:0] qIn;
   logic [`ANGLE_BITS-1:0] angle;
   logic strobe;
   logic signed [`ROT_BITS-1:0] iOut;
   logic signed [`ROT_BITS-1:0] qOut;
   logic valid;

   modport rotator (
      input iIn, qIn, angle, strobe,
      output iOut, qOut, valid
   );

   modport client (
      output iIn, qIn, angle, strobe,
      input iOut, qOut, valid
   );
endinterface

// ==== hdl/trellisPkg.sv ====
package trellisPkg;
`include "trellis_cfg.svh"

   typedef logic signed [`ACS_BITS-1:0] metricT;
   typedef logic signed [`ROT_BITS-1:0] sampleT;
   typedef logic [`ANGLE_BITS-1:0] angleT;

   // even symbols use modulation index 4/16, odd symbols 5/16
   typedef enum logic {parityEven, parityOdd} symParityT;

   // 64*cos(pi*n/16) for the first quadrant, shared by rotator and model
   localparam logic [6:0] cosLut [0:8] = '{7'd64, 7'd63, 7'd59, 7'd53, 7'd45,
                                          7'd36, 7'd24, 7'd12, 7'd0};

   // the 2-bit wrap gives the mod 4 of the trellis rule
   function automatic logic [1:0] predecessor(input logic [1:0] state,
                                               input logic [1:0] branch);
      return state - branch;
   endfunction

   function automatic angleT branchAngle(input logic [1:0] state, input logic [1:0] branch,
                                         input symParityT parity, input angleT tilt);
      logic [3:0] h;
      logic [3:0] offset;
      h = (parity == parityEven) ? 4'd4 : 4'd5;
      // 4-bit arithmetic keeps the offset mod 16
      offset = h * branch + state;
      return angleT'(0) - tilt - {offset, 1'b0};
   endfunction

endpackage

// ==== hdl/trellis_cfg.svh ====
`ifndef TRELLIS_CFG_SVH
`define TRELLIS_CFG_SVH

// path metric width
`define ACS_BITS 12

// rotated sample width, unity gain is 2**(ROT_BITS-2)
`define ROT_BITS 8

// matched-filter sample width, only the top ROT_BITS bits reach the rotator
`define MF_BITS 10

// rotator angle code, 32 steps per turn
`define ANGLE_BITS 5

// trellis states, also the branch count per state
`define NUM_STATES 4

// symEn to symEnOut
`define SYM_LATENCY 8

`endif
